// File: rtl/icache_cfg_pkg.sv
package icache_cfg_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [63:0]  word_t;
    // word 0 sits in the low half
    typedef logic [127:0] line_t;
    // address bits 31:10
    typedef logic [21:0]  tag_t;
    // address bits 9:4
    typedef logic [5:0]   index_t;
    typedef logic [0:0]   way_t;
    typedef logic [1:0]   resp_t;

    localparam resp_t RESP_OKAY = 2'd0;
    localparam resp_t RESP_ERR  = 2'd3;

    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 64;

    // inclusive cacheable window
    localparam addr_t CACHE_START = 32'h8000_0000;
    localparam addr_t CACHE_END   = 32'hBFFF_FFFF;

    // queues hold 7 of 8 slots
    localparam int QUEUE_DEPTH = 7;
    localparam int QUEUE_PTR_W = 3;
    typedef logic [QUEUE_PTR_W-1:0] qptr_t;

    typedef enum logic [2:0] {
        RF_IDLE,
        RF_WAIT_AR,
        RF_WAIT_BEAT0,
        RF_DRAIN_ERROR,
        RF_WAIT_BEAT1,
        RF_WRITE_LINE,
        RF_SEND
    } refill_state_t;

endpackage

// File: rtl/icache_bus_pkg.sv
package icache_bus_pkg;

    // one read beat from memory
    typedef struct packed {
        icache_cfg_pkg::word_t data;
        icache_cfg_pkg::resp_t resp;
        logic                  last;
        logic [3:0]            id;
    } mem_beat_t;

    // 66 bits towards the fetch unit
    typedef struct packed {
        icache_cfg_pkg::resp_t resp;
        icache_cfg_pkg::word_t data;
    } fetch_rsp_t;

    localparam logic [3:0] CACHE_ID    = 4'd3;
    localparam int         BURST_BEATS = 2;

    // fixed burst shape seen by memory
    // len is beats minus one
    localparam logic [7:0] BURST_LEN   = 8'(BURST_BEATS - 1);
    // 8 bytes per beat
    localparam logic [2:0] BURST_SIZE  = 3'd3;
    // incrementing burst
    localparam logic [1:0] BURST_INCR  = 2'd1;

endpackage

// File: rtl/icache_fifo.sv
module icache_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty,
    output logic             full
);

    logic [WIDTH-1:0]      mem [2**icache_cfg_pkg::QUEUE_PTR_W];
    icache_cfg_pkg::qptr_t wr_ptr;
    icache_cfg_pkg::qptr_t rd_ptr;
    icache_cfg_pkg::qptr_t count;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr   = wr_en && !full;
    assign do_rd   = rd_en && !empty;
    assign empty   = (count == '0);
    assign full    = (count == icache_cfg_pkg::qptr_t'(icache_cfg_pkg::QUEUE_DEPTH));
    assign rd_data = mem[rd_ptr];

    // pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (!do_wr && do_rd) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// File: rtl/icache_array.sv
module icache_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inval,
    input  logic                  rd_en,
    input  icache_cfg_pkg::addr_t rd_addr,
    input  icache_cfg_pkg::addr_t lookup_addr,
    input  logic                  stall,
    input  logic                  line_wen,
    input  icache_cfg_pkg::addr_t line_addr,
    input  icache_cfg_pkg::line_t line_data,
    output logic                  hit,
    output icache_cfg_pkg::word_t hit_word
);

    logic [icache_cfg_pkg::NUM_WAYS-1:0][icache_cfg_pkg::NUM_SETS-1:0] valid_q;
    icache_cfg_pkg::tag_t   tag_use  [icache_cfg_pkg::NUM_WAYS];
    icache_cfg_pkg::line_t  line_use [icache_cfg_pkg::NUM_WAYS];
    logic [icache_cfg_pkg::NUM_WAYS-1:0] way_hit;
    icache_cfg_pkg::line_t  hit_line;
    icache_cfg_pkg::index_t port_idx;
    icache_cfg_pkg::index_t line_idx;
    icache_cfg_pkg::index_t look_idx;
    icache_cfg_pkg::way_t   victim;
    logic [7:0]             lfsr;
    logic                   held;

    assign line_idx = line_addr[9:4];
    assign look_idx = lookup_addr[9:4];
    // single port per way, a line write takes the port
    assign port_idx = line_wen ? line_idx : rd_addr[9:4];
    assign victim   = lfsr[0];

    // x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 8'h5a;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            held    <= 1'b0;
        end else begin
            held <= stall;
            if (inval) begin
                valid_q <= '0;
            end else if (line_wen) begin
                valid_q[victim][line_idx] <= 1'b1;
            end
        end
    end

    //**************************************************************************
    // per way storage
    for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : g_way
        icache_cfg_pkg::tag_t  tag_mem  [icache_cfg_pkg::NUM_SETS];
        icache_cfg_pkg::line_t data_mem [icache_cfg_pkg::NUM_SETS];
        icache_cfg_pkg::tag_t  tag_rd;
        icache_cfg_pkg::line_t data_rd;
        icache_cfg_pkg::tag_t  tag_hold;
        icache_cfg_pkg::line_t data_hold;
        logic                  way_wen;

        assign way_wen = line_wen && (victim == icache_cfg_pkg::way_t'(w));

        always_ff @(posedge clk) begin
            if (way_wen) begin
                tag_mem[line_idx]  <= line_addr[31:10];
                data_mem[line_idx] <= line_data;
                tag_rd             <= line_addr[31:10];
                data_rd            <= line_data;
            end else if (rd_en || line_wen) begin
                tag_rd  <= tag_mem[port_idx];
                data_rd <= data_mem[port_idx];
            end
            // freeze what the stalled lookup saw
            if (stall && !held) begin
                tag_hold  <= tag_rd;
                data_hold <= data_rd;
            end
        end

        assign tag_use[w]  = held ? tag_hold : tag_rd;
        assign line_use[w] = held ? data_hold : data_rd;
        assign way_hit[w]  = valid_q[w][look_idx] && (tag_use[w] == lookup_addr[31:10]);
    end

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_line = hit_line | line_use[w];
            end
        end
    end

    assign hit      = |way_hit;
    assign hit_word = lookup_addr[3] ? hit_line[127:64] : hit_line[63:0];

endmodule

// File: rtl/icache_refill.sv
module icache_refill (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       lookup_valid,
    input  icache_cfg_pkg::addr_t      lookup_addr,
    input  logic                       hit,
    input  logic                       rsp_room,
    output logic                       mem_arvalid,
    input  logic                       mem_arready,
    output icache_cfg_pkg::addr_t      mem_araddr,
    input  logic                       mem_rvalid,
    input  icache_bus_pkg::mem_beat_t  mem_beat,
    output logic                       line_wen,
    output icache_cfg_pkg::addr_t      line_addr,
    output icache_cfg_pkg::line_t      line_data,
    output logic                       refill_rsp_valid,
    output icache_bus_pkg::fetch_rsp_t refill_rsp,
    output logic                       busy
);

    icache_cfg_pkg::refill_state_t state;
    icache_cfg_pkg::addr_t         miss_addr;
    icache_cfg_pkg::line_t         line_q;
    icache_cfg_pkg::resp_t         rsp_code;
    logic                          miss;
    logic                          beat_ok;
    logic                          beat_err;
    logic                          cacheable;

    assign miss      = (state == icache_cfg_pkg::RF_IDLE) && lookup_valid && !hit;
    // beats carrying another id are dropped
    assign beat_ok   = mem_rvalid && (mem_beat.id == icache_bus_pkg::CACHE_ID);
    assign beat_err  = (mem_beat.resp != icache_cfg_pkg::RESP_OKAY);
    assign cacheable = (miss_addr >= icache_cfg_pkg::CACHE_START) &&
                       (miss_addr <= icache_cfg_pkg::CACHE_END);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= icache_cfg_pkg::RF_IDLE;
            rsp_code <= icache_cfg_pkg::RESP_OKAY;
        end else if (flush) begin
            state <= icache_cfg_pkg::RF_IDLE;
        end else begin
            case (state)
                icache_cfg_pkg::RF_IDLE: begin
                    if (miss) begin
                        state <= icache_cfg_pkg::RF_WAIT_AR;
                    end
                end
                icache_cfg_pkg::RF_WAIT_AR: begin
                    if (mem_arready) begin
                        state <= icache_cfg_pkg::RF_WAIT_BEAT0;
                    end
                end
                icache_cfg_pkg::RF_WAIT_BEAT0: begin
                    // an error or a short burst both fail the line
                    if (beat_ok && (beat_err || mem_beat.last)) begin
                        rsp_code <= icache_cfg_pkg::RESP_ERR;
                        state    <= mem_beat.last ? icache_cfg_pkg::RF_SEND
                                                  : icache_cfg_pkg::RF_DRAIN_ERROR;
                    end else if (beat_ok) begin
                        state <= icache_cfg_pkg::RF_WAIT_BEAT1;
                    end
                end
                icache_cfg_pkg::RF_DRAIN_ERROR: begin
                    if (beat_ok && mem_beat.last) begin
                        state <= icache_cfg_pkg::RF_SEND;
                    end
                end
                icache_cfg_pkg::RF_WAIT_BEAT1: begin
                    if (beat_ok && !mem_beat.last) begin
                        rsp_code <= icache_cfg_pkg::RESP_ERR;
                        state    <= icache_cfg_pkg::RF_DRAIN_ERROR;
                    end else if (beat_ok && beat_err) begin
                        rsp_code <= icache_cfg_pkg::RESP_ERR;
                        state    <= icache_cfg_pkg::RF_SEND;
                    end else if (beat_ok) begin
                        rsp_code <= icache_cfg_pkg::RESP_OKAY;
                        state    <= cacheable ? icache_cfg_pkg::RF_WRITE_LINE
                                              : icache_cfg_pkg::RF_SEND;
                    end
                end
                icache_cfg_pkg::RF_WRITE_LINE: begin
                    state <= icache_cfg_pkg::RF_SEND;
                end
                icache_cfg_pkg::RF_SEND: begin
                    if (rsp_room) begin
                        state <= icache_cfg_pkg::RF_IDLE;
                    end
                end
                default: begin
                    state <= icache_cfg_pkg::RF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            miss_addr <= lookup_addr;
        end
        if (beat_ok && (state == icache_cfg_pkg::RF_WAIT_BEAT0)) begin
            line_q[63:0] <= mem_beat.data;
        end
        if (beat_ok && (state == icache_cfg_pkg::RF_WAIT_BEAT1)) begin
            line_q[127:64] <= mem_beat.data;
        end
    end

    assign busy             = (state != icache_cfg_pkg::RF_IDLE);
    assign mem_arvalid      = (state == icache_cfg_pkg::RF_WAIT_AR);
    assign mem_araddr       = {miss_addr[31:4], 4'h0};
    assign line_wen         = (state == icache_cfg_pkg::RF_WRITE_LINE);
    assign line_addr        = miss_addr;
    assign line_data        = line_q;
    assign refill_rsp_valid = (state == icache_cfg_pkg::RF_SEND);
    assign refill_rsp.resp  = rsp_code;
    assign refill_rsp.data  = miss_addr[3] ? line_q[127:64] : line_q[63:0];

endmodule

// File: rtl/icache_top.sv
module icache_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       icache_inval,
    input  logic                       ifu_arvalid,
    input  icache_cfg_pkg::addr_t      ifu_araddr,
    output logic                       ifu_arready,
    output logic                       ifu_rvalid,
    output icache_bus_pkg::fetch_rsp_t ifu_rsp,
    input  logic                       ifu_rready,
    output logic                       mem_arvalid,
    output icache_cfg_pkg::addr_t      mem_araddr,
    input  logic                       mem_arready,
    input  logic                       mem_rvalid,
    input  icache_bus_pkg::mem_beat_t  mem_beat
);

    icache_cfg_pkg::addr_t      req_head;
    icache_cfg_pkg::addr_t      stage_addr;
    icache_cfg_pkg::addr_t      line_addr;
    icache_cfg_pkg::line_t      line_data;
    icache_cfg_pkg::word_t      hit_word;
    icache_bus_pkg::fetch_rsp_t refill_rsp;
    icache_bus_pkg::fetch_rsp_t rsp_in;
    logic                       req_empty;
    logic                       req_full;
    logic                       rsp_empty;
    logic                       rsp_full;
    logic                       stage_valid;
    logic                       hit;
    logic                       rsp_push;
    logic                       pop;
    logic                       line_wen;
    logic                       refill_rsp_valid;
    logic                       refill_busy;

    assign ifu_arready = !req_full;
    assign ifu_rvalid  = !rsp_empty;

    // a response retires the lookup stage
    assign rsp_push = ((stage_valid && hit && !refill_busy) || refill_rsp_valid) && !rsp_full;
    assign pop      = !req_empty && (!stage_valid || rsp_push);

    always_comb begin
        if (refill_rsp_valid) begin
            rsp_in = refill_rsp;
        end else begin
            rsp_in.resp = icache_cfg_pkg::RESP_OKAY;
            rsp_in.data = hit_word;
        end
    end

    //**************************************************************************
    // lookup stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;
        end else if (!stage_valid || rsp_push) begin
            stage_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            stage_addr <= req_head;
        end
    end

    icache_fifo #(.WIDTH($bits(icache_cfg_pkg::addr_t))) req_q (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .wr_en(ifu_arvalid && ifu_arready), .wr_data(ifu_araddr),
        .rd_en(pop), .rd_data(req_head), .empty(req_empty), .full(req_full)
    );

    icache_fifo #(.WIDTH($bits(icache_bus_pkg::fetch_rsp_t))) rsp_q (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .wr_en(rsp_push), .wr_data(rsp_in),
        .rd_en(ifu_rvalid && ifu_rready), .rd_data(ifu_rsp), .empty(rsp_empty), .full(rsp_full)
    );

    icache_array array_i (
        .clk(clk), .rst_n(rst_n), .inval(icache_inval),
        .rd_en(pop), .rd_addr(req_head), .lookup_addr(stage_addr),
        .stall(stage_valid && !rsp_push),
        .line_wen(line_wen), .line_addr(line_addr), .line_data(line_data),
        .hit(hit), .hit_word(hit_word)
    );

    icache_refill refill_i (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .lookup_valid(stage_valid), .lookup_addr(stage_addr), .hit(hit),
        .rsp_room(!rsp_full),
        .mem_arvalid(mem_arvalid), .mem_arready(mem_arready), .mem_araddr(mem_araddr),
        .mem_rvalid(mem_rvalid), .mem_beat(mem_beat),
        .line_wen(line_wen), .line_addr(line_addr), .line_data(line_data),
        .refill_rsp_valid(refill_rsp_valid), .refill_rsp(refill_rsp), .busy(refill_busy)
    );

endmodule

// File: tests/icache_mem_model.sv
module icache_mem_model (
    input  logic                      clk,
    input  logic                      stray_en,
    input  logic                      mem_arvalid,
    input  icache_cfg_pkg::addr_t     mem_araddr,
    output logic                      mem_arready,
    output logic                      mem_rvalid,
    output icache_bus_pkg::mem_beat_t mem_beat
);

    logic [31:0]           rand_state;
    icache_cfg_pkg::addr_t burst_addr;
    icache_cfg_pkg::addr_t beat_addr;
    icache_cfg_pkg::resp_t beat_resp;

    // 1 to 4 cycles before each beat
    function automatic logic [31:0] next_delay();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return {30'd0, rand_state[17:16]} + 32'd1;
    endfunction

    function automatic icache_cfg_pkg::word_t beat_data(input icache_cfg_pkg::addr_t addr,
                                                        input logic beat);
        return {32'd0, addr} * 64'h9E37_79B9 + {63'd0, beat};
    endfunction

    task automatic send_beat(input icache_cfg_pkg::word_t data, input icache_cfg_pkg::resp_t resp,
                             input logic last, input logic [3:0] id);
        mem_rvalid    = 1'b1;
        mem_beat.data = data;
        mem_beat.resp = resp;
        mem_beat.last = last;
        mem_beat.id   = id;
        @(negedge clk);
        mem_rvalid = 1'b0;
    endtask

    initial begin
        rand_state  = 32'd2;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_beat    = '0;
        forever begin
            @(negedge clk);
            if (mem_arvalid) begin
                burst_addr  = mem_araddr;
                mem_arready = 1'b1;
                @(negedge clk);
                mem_arready = 1'b0;
                // a beat for some other master, same shape as a short error burst
                if (stray_en) begin
                    send_beat(~beat_data(burst_addr, 1'b0), icache_cfg_pkg::RESP_OKAY,
                              1'b1, 4'd5);
                end
                for (int b = 0; b < icache_bus_pkg::BURST_BEATS; b++) begin
                    repeat (next_delay()) @(negedge clk);
                    beat_addr = burst_addr +
                                icache_cfg_pkg::addr_t'(b << icache_bus_pkg::BURST_SIZE);
                    beat_resp = icache_cfg_pkg::RESP_OKAY;
                    if (b == 0 && burst_addr >= 32'hC000_0000 && burst_addr <= 32'hC000_0FFF) begin
                        beat_resp = icache_cfg_pkg::RESP_ERR;
                    end
                    send_beat(beat_data(beat_addr, 1'(b)), beat_resp,
                              (b == int'(icache_bus_pkg::BURST_LEN)), icache_bus_pkg::CACHE_ID);
                end
            end
        end
    end

endmodule

// File: tests/icache_tb.sv
module icache_tb;

    localparam int WAIT_LIMIT = 2000;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       flush;
    logic                       icache_inval;
    logic                       ifu_arvalid;
    icache_cfg_pkg::addr_t      ifu_araddr;
    logic                       ifu_arready;
    logic                       ifu_rvalid;
    icache_bus_pkg::fetch_rsp_t ifu_rsp;
    logic                       ifu_rready;
    logic                       mem_arvalid;
    icache_cfg_pkg::addr_t      mem_araddr;
    logic                       mem_arready;
    logic                       mem_rvalid;
    icache_bus_pkg::mem_beat_t  mem_beat;
    logic                       stray_en;

    icache_cfg_pkg::addr_t      exp_q [$];
    int                         burst_count;
    string                      test_name;
    logic [31:0]                rand_state;

    always #4 clk = ~clk;

    icache_top icache_top_i (
        .clk(clk), .rst_n(rst_n), .flush(flush), .icache_inval(icache_inval),
        .ifu_arvalid(ifu_arvalid), .ifu_araddr(ifu_araddr), .ifu_arready(ifu_arready),
        .ifu_rvalid(ifu_rvalid), .ifu_rsp(ifu_rsp), .ifu_rready(ifu_rready),
        .mem_arvalid(mem_arvalid), .mem_araddr(mem_araddr), .mem_arready(mem_arready),
        .mem_rvalid(mem_rvalid), .mem_beat(mem_beat)
    );

    icache_mem_model mem_model_i (
        .clk(clk), .stray_en(stray_en),
        .mem_arvalid(mem_arvalid), .mem_araddr(mem_araddr), .mem_arready(mem_arready),
        .mem_rvalid(mem_rvalid), .mem_beat(mem_beat)
    );

    //**************************************************************************
    // reference rules and checks
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return {16'd0, rand_state[31:16]};
    endfunction

    // whole line fails when beat 0 is in the error window
    function automatic icache_bus_pkg::fetch_rsp_t expected_rsp(input icache_cfg_pkg::addr_t addr);
        icache_bus_pkg::fetch_rsp_t rsp;
        rsp.data = {32'd0, addr[31:3], 3'd0} * 64'h9E37_79B9 + {63'd0, addr[3]};
        rsp.resp = icache_cfg_pkg::RESP_OKAY;
        if (addr >= 32'hC000_0000 && addr <= 32'hC000_0FFF) begin
            rsp.resp = icache_cfg_pkg::RESP_ERR;
        end
        return rsp;
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out in %s while waiting for %s", test_name, what);
        stop_with_failure();
    endtask

    task automatic check_response();
        icache_bus_pkg::fetch_rsp_t exp;
        assert (exp_q.size() != 0) else begin
            $display("response arrived in %s with no request outstanding", test_name);
            stop_with_failure();
        end
        exp = expected_rsp(exp_q.pop_front());
        check_value("resp", 64'(exp.resp), 64'(ifu_rsp.resp));
        if (exp.resp == icache_cfg_pkg::RESP_OKAY) begin
            check_value("data", exp.data, ifu_rsp.data);
        end
    endtask

    // sampled before the edge updates anything
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_arvalid && mem_arready) begin
                burst_count++;
                check_value("araddr low bits", 64'd0, 64'(mem_araddr[3:0]));
            end
            if (flush) begin
                exp_q.delete();
            end else begin
                if (ifu_rvalid && ifu_rready) begin
                    check_response();
                end
                if (ifu_arvalid && ifu_arready) begin
                    exp_q.push_back(ifu_araddr);
                end
            end
        end
    end

    //**************************************************************************
    // stimulus helpers, all called on a falling edge
    task automatic send_request(input icache_cfg_pkg::addr_t addr);
        int guard;
        guard = 0;
        while (!ifu_arready) begin
            @(negedge clk);
            guard++;
            if (guard > WAIT_LIMIT) begin
                report_timeout("ifu_arready");
            end
        end
        ifu_arvalid = 1'b1;
        ifu_araddr  = addr;
        @(negedge clk);
        ifu_arvalid = 1'b0;
    endtask

    task automatic wait_drained();
        int guard;
        guard = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            guard++;
            if (guard > WAIT_LIMIT) begin
                report_timeout("outstanding responses");
            end
        end
    endtask

    task automatic wait_rvalid();
        int guard;
        guard = 0;
        while (!ifu_rvalid) begin
            @(negedge clk);
            guard++;
            if (guard > WAIT_LIMIT) begin
                report_timeout("ifu_rvalid");
            end
        end
    endtask

    task automatic fetch_one(input icache_cfg_pkg::addr_t addr);
        send_request(addr);
        wait_drained();
    endtask

    task automatic check_bursts(input int exp);
        check_value("bursts", 64'(exp), 64'(burst_count));
    endtask

    task automatic pulse_inval();
        icache_inval = 1'b1;
        @(negedge clk);
        icache_inval = 1'b0;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    //**************************************************************************
    initial begin
        int                    base;
        int                    sent;
        int                    guard;
        logic [31:0]           r;
        icache_cfg_pkg::addr_t addr;
        rst_n        = 1'b0;
        flush        = 1'b0;
        icache_inval = 1'b0;
        ifu_arvalid  = 1'b0;
        ifu_araddr   = '0;
        ifu_rready   = 1'b1;
        stray_en     = 1'b0;
        rand_state   = 32'd2;
        burst_count  = 0;
        test_name    = "reset";
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("ifu_rvalid", 64'd0, 64'(ifu_rvalid));
        check_value("mem_arvalid", 64'd0, 64'(mem_arvalid));
        check_value("ifu_arready", 64'd1, 64'(ifu_arready));

        test_name = "cached_line";
        base = burst_count;
        fetch_one(32'h8000_1230);
        check_bursts(base + 1);
        fetch_one(32'h8000_1238);
        check_bursts(base + 1);

        test_name = "uncached";
        base = burst_count;
        fetch_one(32'hD000_0048);
        check_bursts(base + 1);
        fetch_one(32'hD000_0048);
        check_bursts(base + 2);

        test_name = "bus_error";
        base = burst_count;
        fetch_one(32'hC000_0108);
        check_bursts(base + 1);
        fetch_one(32'hC000_0108);
        check_bursts(base + 2);

        test_name = "invalidate";
        pulse_inval();
        base = burst_count;
        fetch_one(32'h8000_1230);
        check_bursts(base + 1);
        fetch_one(32'h8000_1238);
        check_bursts(base + 1);

        test_name  = "flush";
        ifu_rready = 1'b0;
        send_request(32'h8000_1230);
        send_request(32'h8000_1238);
        send_request(32'h8000_1230);
        wait_rvalid();
        pulse_flush();
        ifu_rready = 1'b1;
        // queued requests must leave no trace
        for (int i = 0; i < 4; i++) begin
            check_value("ifu_rvalid after flush", 64'd0, 64'(ifu_rvalid));
            @(negedge clk);
        end
        base = burst_count;
        fetch_one(32'h8000_2000);
        check_bursts(base + 1);

        // three lines on set 5
        test_name = "random_same_index";
        stray_en  = 1'b1;
        sent      = 0;
        guard     = 0;
        while (sent < 40) begin
            r = next_rand();
            ifu_rready = r[8];
            if (ifu_arready) begin
                ifu_arvalid = 1'b1;
                ifu_araddr  = 32'h8000_0050 + 32'h400 * (32'd1 + r % 32'd3) + {28'd0, r[4], 3'd0};
                sent++;
            end else begin
                ifu_arvalid = 1'b0;
            end
            @(negedge clk);
            guard++;
            if (guard > WAIT_LIMIT) begin
                report_timeout("random requests to be accepted");
            end
        end
        ifu_arvalid = 1'b0;
        ifu_rready  = 1'b1;
        wait_drained();

        test_name  = "backpressure";
        ifu_rready = 1'b0;
        sent       = 0;
        while (ifu_arready) begin
            assert (sent < icache_cfg_pkg::QUEUE_DEPTH * 2 + 2) else begin
                $display("ifu_arready still high after %0d requests in %s", sent, test_name);
                stop_with_failure();
            end
            addr = 32'h8000_0450 + 32'h400 * (sent % 3) + 32'((sent / 3) % 2 * 8);
            send_request(addr);
            sent++;
        end
        ifu_rready = 1'b1;
        wait_drained();

        $display("TEST OK");
        $finish;
    end

endmodule

// File: icache.f
rtl/icache_cfg_pkg.sv
rtl/icache_bus_pkg.sv
rtl/icache_fifo.sv
rtl/icache_array.sv
rtl/icache_refill.sv
rtl/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f icache.f --top-module icache_tb -o icache_sim
	./obj_dir/icache_sim | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
